/* common/uart_defs.svh */
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Clock cycles per serial bit as a fixed divisor of clk
`define UART_CLKS_PER_BIT 8

// Entries in the transmit byte FIFO, which must be a power of two
`define TX_FIFO_DEPTH 16

// Address bits of the debug memory
`define MEM_ADDR_W 8

`endif

/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

  // One 8N1 payload byte
  typedef logic [7:0] uart_byte_t;

  // Receiver FSM
  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } uart_rx_state_e;

  // Transmitter FSM
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } uart_tx_state_e;

endpackage

`default_nettype wire

/* common/debug_pkg.sv */
`default_nettype none
`include "uart_defs.svh"

package debug_pkg;

  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

  // Byte values of the debug protocol
  typedef enum logic [7:0] {
    CODE_EOT   = 8'h04,
    CODE_ACK   = 8'h06,
    CODE_READ  = 8'h11,
    CODE_WRITE = 8'h12
  } debug_code_e;

  // Command engine FSM
  typedef enum logic [2:0] {
    CMD_IDLE,
    CMD_GET_ADDR,
    CMD_GET_LEN,
    CMD_SEND_ACK,
    CMD_WRITE_DATA,
    CMD_READ_FETCH,
    CMD_READ_PUSH,
    CMD_SEND_EOT
  } cmd_state_e;

endpackage

`default_nettype wire

/* logic/uart_rx.sv */
`default_nettype none
`include "uart_defs.svh"

module uart_rx (
  input  wire logic                 clk,
  input  wire logic                 reset_i,
  input  wire logic                 rx_i,
  output uart_pkg::uart_byte_t      rx_byte_o,
  output logic                      rx_valid_o
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`UART_CLKS_PER_BIT - 1);
  localparam logic [cnt_w-1:0] cnt_half = cnt_w'(`UART_CLKS_PER_BIT / 2 - 1);

  uart_rx_state_e   state_q;
  logic [1:0]       sync_q;
  logic [cnt_w-1:0] cnt_q;
  logic [2:0]       bit_q;
  uart_byte_t       shift_q;
  logic             valid_q;
  logic             rx_s;

  // Serial line after the two-flop synchronizer
  assign rx_s = sync_q[1];

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sync_q  <= 2'b11;
      state_q <= RX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      sync_q  <= {sync_q[0], rx_i};
      valid_q <= 1'b0;
      case (state_q)
        RX_IDLE: begin
          cnt_q <= '0;
          if (!rx_s) state_q <= RX_START;
        end
        RX_START: begin
          // Confirm the start bit at half a bit, else treat it as a glitch
          if (cnt_q == cnt_half) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RX_DATA: begin
          if (cnt_q == cnt_last) begin
            cnt_q <= '0;
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= RX_STOP;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: begin
          // A low stop bit drops the frame
          if (cnt_q == cnt_last) begin
            valid_q <= rx_s;
            state_q <= RX_IDLE;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
      endcase
    end
  end

  // LSB first, sampled at bit centres
  always_ff @(posedge clk) begin
    if (state_q == RX_DATA && cnt_q == cnt_last) shift_q <= {rx_s, shift_q[7:1]};
  end

  assign rx_byte_o  = shift_q;
  assign rx_valid_o = valid_q;

endmodule

`default_nettype wire

/* logic/uart_tx.sv */
`default_nettype none
`include "uart_defs.svh"

module uart_tx (
  input  wire logic                 clk,
  input  wire logic                 reset_i,
  input  wire logic                 empty_i,
  input  wire uart_pkg::uart_byte_t byte_i,
  output logic                      pop_o,
  output logic                      tx_o
);

  import uart_pkg::*;

  localparam int cnt_w = $clog2(`UART_CLKS_PER_BIT);
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`UART_CLKS_PER_BIT - 1);

  uart_tx_state_e   state_q;
  logic [cnt_w-1:0] cnt_q;
  logic [2:0]       bit_q;
  uart_byte_t       shift_q;
  logic             tx_q;
  logic             bit_end;

  assign bit_end = (cnt_q == cnt_last);

  // Take the head byte when idle, or right at the end of a stop bit
  assign pop_o = !empty_i && (state_q == TX_IDLE || (state_q == TX_STOP && bit_end));

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= TX_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      tx_q    <= 1'b1;
    end else begin
      cnt_q <= (state_q == TX_IDLE || bit_end) ? '0 : cnt_q + 1'b1;
      if (pop_o) begin
        state_q <= TX_START;
        tx_q    <= 1'b0;
      end else if (bit_end) begin
        case (state_q)
          TX_START: begin
            state_q <= TX_DATA;
            bit_q   <= '0;
            tx_q    <= shift_q[0];
          end
          TX_DATA: begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= TX_STOP;
              tx_q    <= 1'b1;
            end else begin
              tx_q <= shift_q[bit_q + 3'd1];
            end
          end
          default: begin
            state_q <= TX_IDLE;
            tx_q    <= 1'b1;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) shift_q <= byte_i;
  end

  assign tx_o = tx_q;

endmodule

`default_nettype wire

/* logic/byte_fifo.sv */
`default_nettype none
`include "uart_defs.svh"

module byte_fifo #(
  parameter int depth = `TX_FIFO_DEPTH
) (
  input  wire logic                 clk,
  input  wire logic                 reset_i,
  input  wire logic                 push_i,
  input  wire uart_pkg::uart_byte_t push_byte_i,
  input  wire logic                 pop_i,
  output logic                      full_o,
  output logic                      empty_o,
  output uart_pkg::uart_byte_t      pop_byte_o
);

  import uart_pkg::*;

  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = ptr_w + 1;

  uart_byte_t       buf_q [depth];
  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (count_q == cnt_w'(depth));
  assign empty_o = (count_q == '0);

  // Pushes into a full FIFO and pops from an empty one are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (do_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) buf_q[wr_ptr_q] <= push_byte_i;
  end

  // Head byte is valid whenever empty_o is low
  assign pop_byte_o = buf_q[rd_ptr_q];

endmodule

`default_nettype wire

/* debug_server/debug_mem.sv */
`default_nettype none
`include "uart_defs.svh"

module debug_mem (
  input  wire logic                 clk,
  input  wire logic                 we_i,
  input  wire logic                 re_i,
  input  wire debug_pkg::mem_addr_t addr_i,
  input  wire uart_pkg::uart_byte_t wdata_i,
  output uart_pkg::uart_byte_t      rdata_o
);

  import uart_pkg::*;

  uart_byte_t mem_q [2**`MEM_ADDR_W];
  uart_byte_t rdata_q;

  always_ff @(posedge clk) begin
    if (we_i) mem_q[addr_i] <= wdata_i;
  end

  // Read data holds until the next read
  always_ff @(posedge clk) begin
    if (re_i) rdata_q <= mem_q[addr_i];
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

/* debug_server/debug_cmd_engine.sv */
`default_nettype none
`include "uart_defs.svh"

module debug_cmd_engine (
  input  wire logic                 clk,
  input  wire logic                 reset_i,
  input  wire uart_pkg::uart_byte_t rx_byte_i,
  input  wire logic                 rx_valid_i,
  input  wire logic                 full_i,
  input  wire uart_pkg::uart_byte_t mem_rdata_i,
  output logic                      push_o,
  output uart_pkg::uart_byte_t      push_byte_o,
  output logic                      mem_we_o,
  output logic                      mem_re_o,
  output debug_pkg::mem_addr_t      mem_addr_o,
  output uart_pkg::uart_byte_t      mem_wdata_o
);

  import uart_pkg::*;
  import debug_pkg::*;

  cmd_state_e  state_q;
  debug_code_e op_q;
  mem_addr_t   addr_q;
  uart_byte_t  len_q;
  logic        we_q;
  uart_byte_t  wdata_q;
  logic        last_byte;

  assign last_byte = (len_q == 8'd1);

  // Reply bytes go out only while the FIFO has room
  always_comb begin
    push_o      = 1'b0;
    push_byte_o = mem_rdata_i;
    case (state_q)
      CMD_SEND_ACK: begin
        push_o      = !full_i;
        push_byte_o = uart_byte_t'(CODE_ACK);
      end
      CMD_SEND_EOT: begin
        push_o      = !full_i;
        push_byte_o = uart_byte_t'(CODE_EOT);
      end
      CMD_READ_PUSH: push_o = !full_i;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= CMD_IDLE;
      op_q    <= CODE_ACK;
      addr_q  <= '0;
      len_q   <= '0;
      we_q    <= 1'b0;
    end else begin
      we_q <= 1'b0;
      // Each stored byte moves the address on, wrapping at the top
      if (we_q) addr_q <= addr_q + 1'b1;
      case (state_q)
        CMD_IDLE: begin
          if (rx_valid_i) begin
            if (rx_byte_i == CODE_ACK) begin
              op_q    <= CODE_ACK;
              state_q <= CMD_SEND_ACK;
            end else if (rx_byte_i == CODE_READ || rx_byte_i == CODE_WRITE) begin
              op_q    <= debug_code_e'(rx_byte_i);
              state_q <= CMD_GET_ADDR;
            end
          end
        end
        CMD_GET_ADDR: begin
          if (rx_valid_i) begin
            addr_q  <= mem_addr_t'(rx_byte_i);
            state_q <= CMD_GET_LEN;
          end
        end
        CMD_GET_LEN: begin
          if (rx_valid_i) begin
            len_q   <= rx_byte_i;
            state_q <= CMD_SEND_ACK;
          end
        end
        CMD_SEND_ACK: begin
          if (!full_i) begin
            if (op_q == CODE_ACK) begin
              state_q <= CMD_IDLE;
            end else if (len_q == '0) begin
              state_q <= CMD_SEND_EOT;
            end else if (op_q == CODE_WRITE) begin
              state_q <= CMD_WRITE_DATA;
            end else begin
              state_q <= CMD_READ_FETCH;
            end
          end
        end
        CMD_WRITE_DATA: begin
          if (rx_valid_i) begin
            we_q  <= 1'b1;
            len_q <= len_q - 1'b1;
            if (last_byte) state_q <= CMD_SEND_EOT;
          end
        end
        CMD_READ_FETCH: state_q <= CMD_READ_PUSH;
        CMD_READ_PUSH: begin
          // Fetched byte waits here while the FIFO is full
          if (!full_i) begin
            addr_q  <= addr_q + 1'b1;
            len_q   <= len_q - 1'b1;
            state_q <= last_byte ? CMD_SEND_EOT : CMD_READ_FETCH;
          end
        end
        default: begin
          if (!full_i) state_q <= CMD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == CMD_WRITE_DATA && rx_valid_i) wdata_q <= rx_byte_i;
  end

  assign mem_we_o    = we_q;
  assign mem_wdata_o = wdata_q;
  assign mem_re_o    = (state_q == CMD_READ_FETCH);
  assign mem_addr_o  = addr_q;

endmodule

`default_nettype wire

/* debug_server/uart_debug_top.sv */
`default_nettype none
`include "uart_defs.svh"

module uart_debug_top (
  input  wire logic clk,
  input  wire logic reset_i,
  input  wire logic rx_i,
  output logic      tx_o
);

  import uart_pkg::*;
  import debug_pkg::*;

  uart_byte_t rx_byte;
  logic       rx_valid;
  logic       push;
  uart_byte_t push_byte;
  logic       full;
  logic       empty;
  logic       pop;
  uart_byte_t pop_byte;
  logic       mem_we;
  logic       mem_re;
  mem_addr_t  mem_addr;
  uart_byte_t mem_wdata;
  uart_byte_t mem_rdata;

  uart_rx i_uart_rx (
    .clk        ( clk      ),
    .reset_i    ( reset_i  ),
    .rx_i       ( rx_i     ),
    .rx_byte_o  ( rx_byte  ),
    .rx_valid_o ( rx_valid )
  );

  debug_cmd_engine i_debug_cmd_engine (
    .clk         ( clk       ),
    .reset_i     ( reset_i   ),
    .rx_byte_i   ( rx_byte   ),
    .rx_valid_i  ( rx_valid  ),
    .full_i      ( full      ),
    .mem_rdata_i ( mem_rdata ),
    .push_o      ( push      ),
    .push_byte_o ( push_byte ),
    .mem_we_o    ( mem_we    ),
    .mem_re_o    ( mem_re    ),
    .mem_addr_o  ( mem_addr  ),
    .mem_wdata_o ( mem_wdata )
  );

  debug_mem i_debug_mem (
    .clk     ( clk       ),
    .we_i    ( mem_we    ),
    .re_i    ( mem_re    ),
    .addr_i  ( mem_addr  ),
    .wdata_i ( mem_wdata ),
    .rdata_o ( mem_rdata )
  );

  // Reply queue between engine and transmitter
  byte_fifo #(
    .depth ( `TX_FIFO_DEPTH )
  ) i_byte_fifo (
    .clk         ( clk       ),
    .reset_i     ( reset_i   ),
    .push_i      ( push      ),
    .push_byte_i ( push_byte ),
    .pop_i       ( pop       ),
    .full_o      ( full      ),
    .empty_o     ( empty     ),
    .pop_byte_o  ( pop_byte  )
  );

  uart_tx i_uart_tx (
    .clk     ( clk      ),
    .reset_i ( reset_i  ),
    .empty_i ( empty    ),
    .byte_i  ( pop_byte ),
    .pop_o   ( pop      ),
    .tx_o    ( tx_o     )
  );

endmodule

`default_nettype wire

/* bench/tb_uart_debug.sv */
`default_nettype none
`include "uart_defs.svh"

module tb_uart_debug;

  timeunit 1ns;
  timeprecision 1ps;

  import uart_pkg::*;
  import debug_pkg::*;

  localparam int reply_timeout  = `UART_CLKS_PER_BIT * 10 * 100;
  localparam int silence_cycles = `UART_CLKS_PER_BIT * 10 * 3;

  logic clk;
  logic reset_i;
  logic rx_i;
  logic tx_o;

  uart_byte_t  model_mem [2**`MEM_ADDR_W];
  uart_byte_t  wr_data_q [$];
  uart_byte_t  exp_q [$];
  bit          code_q [$];
  logic [31:0] lcg_state = 32'd52233;

  uart_debug_top i_uart_debug_top (
    .clk     ( clk     ),
    .reset_i ( reset_i ),
    .rx_i    ( rx_i    ),
    .tx_o    ( tx_o    )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic uart_byte_t next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Queues the expected reply of one command and updates the memory copy on writes
  function automatic void model_command(input uart_byte_t op, input uart_byte_t addr,
                                        input uart_byte_t len);
    mem_addr_t a;
    int        i;
    if (op == CODE_ACK) begin
      exp_q.push_back(CODE_ACK);
      code_q.push_back(1'b1);
    end else if (op == CODE_READ || op == CODE_WRITE) begin
      exp_q.push_back(CODE_ACK);
      code_q.push_back(1'b1);
      a = addr;
      for (i = 0; i < len; i++) begin
        if (op == CODE_WRITE) begin
          model_mem[a] = wr_data_q[i];
        end else begin
          exp_q.push_back(model_mem[a]);
          code_q.push_back(1'b0);
        end
        a = a + 1'b1;
      end
      exp_q.push_back(CODE_EOT);
      code_q.push_back(1'b1);
    end
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_code(input debug_code_e expected, input debug_code_e actual,
                            input string name);
    if (actual !== expected) begin
      $display("ERR %0t: %s expected code %h, got %h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  task automatic check_data(input uart_byte_t expected, input uart_byte_t actual,
                            input int index, input string name);
    if (actual !== expected) begin
      $display("ERR %0t: %s reply byte %0d expected %h, got %h",
               $time, name, index, expected, actual);
      abort_run();
    end
  endtask

  // Holds one bit on rx_i from a falling edge
  task automatic hold_bit(input logic value);
    @(negedge clk);
    rx_i = value;
    repeat (`UART_CLKS_PER_BIT - 1) @(negedge clk);
  endtask

  task automatic drive_byte(input uart_byte_t value);
    int i;
    hold_bit(1'b0);
    for (i = 0; i < 8; i++) hold_bit(value[i]);
    hold_bit(1'b1);
  endtask

  // Waits up to limit cycles for a start bit, then samples at bit centres
  task automatic receive_byte(input int limit, output uart_byte_t value, output bit ok);
    int n;
    int i;
    ok    = 1'b0;
    value = '0;
    n     = 0;
    do begin
      @(negedge clk);
      n++;
    end while (tx_o !== 1'b0 && n < limit);
    if (tx_o === 1'b0) begin
      repeat (`UART_CLKS_PER_BIT / 2) @(negedge clk);
      if (tx_o !== 1'b0) begin
        $display("Start bit on tx_o ended before its centre at %0t", $time);
        abort_run();
      end
      for (i = 0; i < 8; i++) begin
        repeat (`UART_CLKS_PER_BIT) @(negedge clk);
        value[i] = tx_o;
      end
      repeat (`UART_CLKS_PER_BIT) @(negedge clk);
      if (tx_o !== 1'b1) begin
        $display("Stop bit on tx_o was not high at %0t", $time);
        abort_run();
      end
      ok = 1'b1;
    end
  endtask

  task automatic compare_replies(input string name);
    uart_byte_t got;
    uart_byte_t expected;
    bit         ok;
    bit         is_code;
    int         idx;
    idx = 0;
    while (exp_q.size() > 0) begin
      receive_byte(reply_timeout, got, ok);
      if (!ok) begin
        $display("Timed out waiting for reply byte %0d of %s", idx, name);
        abort_run();
      end
      expected = exp_q.pop_front();
      is_code  = code_q.pop_front();
      if (is_code) check_code(debug_code_e'(expected), debug_code_e'(got), name);
      else check_data(expected, got, idx, name);
      idx++;
    end
  endtask

  // Sends one command while the replies are checked alongside
  task automatic run_command(input uart_byte_t op, input uart_byte_t addr,
                             input uart_byte_t len, input string name);
    uart_byte_t send_q [$];
    uart_byte_t extra;
    bit         ok;
    send_q.push_back(op);
    if (op == CODE_READ || op == CODE_WRITE) begin
      send_q.push_back(addr);
      send_q.push_back(len);
    end
    if (op == CODE_WRITE) begin
      foreach (wr_data_q[i]) send_q.push_back(wr_data_q[i]);
    end
    model_command(op, addr, len);
    fork
      foreach (send_q[i]) drive_byte(send_q[i]);
      compare_replies(name);
    join
    // Nothing more may follow the expected reply
    receive_byte(silence_cycles, extra, ok);
    if (ok) begin
      $display("Unexpected extra byte %h on tx_o after %s", extra, name);
      abort_run();
    end
    wr_data_q.delete();
  endtask

  task automatic fill_data(input int count);
    int i;
    for (i = 0; i < count; i++) wr_data_q.push_back(next_rand());
  endtask

  initial begin
    rx_i    = 1'b1;
    reset_i = 1'b1;
    repeat (16) @(negedge clk);
    reset_i = 1'b0;
    repeat (4) @(negedge clk);

    run_command(CODE_ACK, 8'h00, 8'h00, "ack challenge");

    fill_data(8);
    run_command(CODE_WRITE, 8'h20, 8'd8, "write 8 at 0x20");
    run_command(CODE_READ, 8'h20, 8'd8, "read 8 at 0x20");

    // Crosses the top of the address space
    fill_data(6);
    run_command(CODE_WRITE, 8'hFD, 8'd6, "write 6 at 0xFD");
    run_command(CODE_READ, 8'hFD, 8'd6, "read 6 at 0xFD");

    run_command(8'h55, 8'h00, 8'h00, "unknown byte 0x55");
    run_command(CODE_READ, 8'h20, 8'd8, "read after unknown byte");

    // Longer than the reply FIFO
    fill_data(40);
    run_command(CODE_WRITE, 8'h80, 8'd40, "write 40 at 0x80");
    run_command(CODE_READ, 8'h80, 8'd40, "read 40 at 0x80");

    run_command(CODE_READ, 8'h40, 8'd0, "read length 0");

    $display("PASS: all tests");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+common
common/uart_pkg.sv
common/debug_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/byte_fifo.sv
debug_server/debug_mem.sv
debug_server/debug_cmd_engine.sv
debug_server/uart_debug_top.sv
bench/tb_uart_debug.sv
